//--- Makefile
# Verilator build and run of the tiled RAM testbench

TOP := tb_tiled_ram

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

//--- ram_addr_decoder.sv
// ------------------------------------------------
// Steers a request to one tile by address and flags addresses beyond the RAM
// Each tile output and the error flag go through their own valid pipeline
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ram_addr_decoder (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      in_valid,
  input  ram_pkg::ram_req_t                         in,
  output logic              [ram_pkg::TILES-1:0]    out_valid,
  output ram_pkg::tile_req_t [ram_pkg::TILES-1:0]   out,
  output logic                                      err
);

  import ram_pkg::*;

  // First address past the end of the RAM
  localparam logic [ADDR_W-1:0] END_ADDR = ADDR_W'(DEPTH);

  logic                   in_range;
  logic                   dec_err;
  logic      [TILES-1:0]  dec_valid;
  tile_req_t [TILES-1:0]  dec_req;

  // Anything at or above DEPTH goes to no tile and turns into an error pulse
  assign in_range = (in.addr < END_ADDR);
  assign dec_err  = in_valid && !in_range;

  // ------------------------------------------------
  // Tile select
  // ------------------------------------------------

  if (DEPTH_IS_POW2) begin : gen_msb_select
    // The spare top bit marks out of range, the tile select sits just below it
    localparam int SEL_W   = $clog2(TILES);
    localparam int SEL_LSB = ADDR_W - 1 - SEL_W;

    logic [SEL_W-1:0] sel;

    assign sel = in.addr[ADDR_W-2:SEL_LSB];

    for (genvar i = 0; i < TILES; i++) begin : gen_tile
      assign dec_valid[i]         = in_valid && in_range && (sel == SEL_W'(i));
      // Low bits are the offset directly when tiles are power-of-two aligned
      assign dec_req[i].tile_addr = in.addr[TILE_ADDR_W-1:0];
      assign dec_req[i].op        = in.op;
      assign dec_req[i].wdata     = in.wdata;
    end
  end else begin : gen_range_select
    for (genvar i = 0; i < TILES; i++) begin : gen_tile
      // Base is inclusive and bound is exclusive
      localparam logic [ADDR_W-1:0] TILE_BASE  = ADDR_W'(TILE_DEPTH * i);
      localparam logic [ADDR_W-1:0] TILE_BOUND = ADDR_W'(TILE_DEPTH * (i + 1));

      assign dec_valid[i] = in_valid && in_range &&
                            (in.addr >= TILE_BASE) && (in.addr < TILE_BOUND);
      // Tile bases are not aligned here, so the offset needs a real subtraction
      assign dec_req[i].tile_addr = TILE_ADDR_W'(in.addr - TILE_BASE);
      assign dec_req[i].op        = in.op;
      assign dec_req[i].wdata     = in.wdata;
    end
  end

  // ------------------------------------------------
  // Output pipelines
  // ------------------------------------------------

  // One copy per tile keeps the fanout of each register low
  for (genvar i = 0; i < TILES; i++) begin : gen_out
    ram_delay_valid delay_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (dec_valid[i]),
      .in        (dec_req[i]),
      .out_valid (out_valid[i]),
      .out       (out[i])
    );
  end

  // Error flag rides a pipeline of the same depth with no payload
  ram_delay_valid err_delay_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (dec_err),
    .in        ('0),
    .out_valid (err),
    .out       ()
  );

endmodule : ram_addr_decoder

`default_nettype wire

//--- ram_delay_valid.sv
// ------------------------------------------------
// Valid pipeline of DECODE_STAGES registers carrying one tile request
// Passes straight through when DECODE_STAGES is zero
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ram_delay_valid (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  ram_pkg::tile_req_t in,
  output logic              out_valid,
  output ram_pkg::tile_req_t out
);

  import ram_pkg::*;

  // Index 0 is the input itself, the last index feeds the outputs
  logic      [DECODE_STAGES:0] valid_stg;
  tile_req_t [DECODE_STAGES:0] data_stg;

  assign valid_stg[0] = in_valid;
  assign data_stg[0]  = in;

  for (genvar s = 1; s <= DECODE_STAGES; s++) begin : gen_stage
    // Valid bits are control state and are cleared on reset
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_stg[s] <= 1'b0;
      end else begin
        valid_stg[s] <= valid_stg[s-1];
      end
    end

    // Payload only moves along with a valid, so idle cycles do not toggle it
    always_ff @(posedge clk) begin
      if (valid_stg[s-1]) begin
        data_stg[s] <= data_stg[s-1];
      end
    end
  end

  assign out_valid = valid_stg[DECODE_STAGES];
  assign out       = data_stg[DECODE_STAGES];

endmodule : ram_delay_valid

`default_nettype wire

//--- ram_pkg.sv
// ------------------------------------------------
// Shared sizes, opcodes and request/response types for the tiled scratchpad RAM
// ------------------------------------------------
`default_nettype none

package ram_pkg;

  // ------------------------------------------------
  // Sizes
  // ------------------------------------------------

  // Total number of words across all tiles
  localparam int DEPTH = 24;
  // Number of tiles, which must divide DEPTH evenly
  localparam int TILES = 3;
  // Words held by each tile
  localparam int TILE_DEPTH = DEPTH / TILES;
  // One spare MSB so that out-of-range addresses can be presented
  localparam int ADDR_W = $clog2(DEPTH) + 1;
  // Offset width inside a single tile
  localparam int TILE_ADDR_W = $clog2(TILE_DEPTH);
  // Word width
  localparam int DATA_W = 16;

  // ------------------------------------------------
  // Timing and decode selection
  // ------------------------------------------------

  // Register stages between the decode logic and the tiles
  localparam int DECODE_STAGES = 1;
  // High when DEPTH is a power of two, so the MSBs can select the tile directly
  localparam bit DEPTH_IS_POW2 = ((DEPTH & (DEPTH - 1)) == 0);

  // ------------------------------------------------
  // Types
  // ------------------------------------------------

  typedef enum logic {
    RAM_OP_READ  = 1'b0,
    RAM_OP_WRITE = 1'b1
  } ram_op_e;

  // Request as seen on the top-level port
  typedef struct packed {
    ram_op_e                   op;
    logic [ADDR_W-1:0]         addr;
    logic [DATA_W-1:0]         wdata;
  } ram_req_t;

  // Request after decode, addressed within one tile
  typedef struct packed {
    ram_op_e                   op;
    logic [TILE_ADDR_W-1:0]    tile_addr;
    logic [DATA_W-1:0]         wdata;
  } tile_req_t;

  // Response, err marks an address outside the RAM
  typedef struct packed {
    logic [DATA_W-1:0]         rdata;
    logic                      err;
  } ram_rsp_t;

endpackage : ram_pkg

`default_nettype wire

//--- ram_rsp_collect.sv
// ------------------------------------------------
// Merges per-tile read results and the decode error onto one registered response
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ram_rsp_collect (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic [ram_pkg::TILES-1:0]                         rd_valid,
  input  logic [ram_pkg::TILES-1:0][ram_pkg::DATA_W-1:0]    rdata,
  input  logic                                              err,
  output logic                                              rsp_valid,
  output ram_pkg::ram_rsp_t                                 rsp
);

  import ram_pkg::*;

  logic              err_q;
  logic              any_rd;
  logic              rsp_next;
  logic [DATA_W-1:0] merged;

  // At most one tile pulses in a cycle, so a masked OR picks its data
  always_comb begin
    merged = '0;
    for (int i = 0; i < TILES; i++) begin
      if (rd_valid[i]) begin
        merged = merged | rdata[i];
      end
    end
  end

  assign any_rd   = |rd_valid;
  assign rsp_next = any_rd || err_q;

  // The error skips the tile stage, so one register lines it up with read data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      err_q     <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      err_q     <= err;
      rsp_valid <= rsp_next;
    end
  end

  // Error responses carry zero data
  always_ff @(posedge clk) begin
    if (rsp_next) begin
      rsp.rdata <= err_q ? '0 : merged;
      rsp.err   <= err_q;
    end
  end

endmodule : ram_rsp_collect

`default_nettype wire

//--- ram_tile.sv
// ------------------------------------------------
// One RAM tile of flop storage with a registered read
// Writes land on the next edge, reads return one cycle later with rd_valid
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ram_tile (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          req_valid,
  input  ram_pkg::tile_req_t            req,
  output logic                          rd_valid,
  output logic [ram_pkg::DATA_W-1:0]    rdata
);

  import ram_pkg::*;

  logic [DATA_W-1:0] mem [TILE_DEPTH];
  logic              do_write;
  logic              do_read;

  assign do_write = req_valid && (req.op == RAM_OP_WRITE);
  assign do_read  = req_valid && (req.op == RAM_OP_READ);

  // Storage itself has no reset, contents are undefined until written
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[req.tile_addr] <= req.wdata;
    end
  end

  // Read data is held until the next read, only rd_valid marks it fresh
  always_ff @(posedge clk) begin
    if (do_read) begin
      rdata <= mem[req.tile_addr];
    end
  end

  // One-cycle pulse per accepted read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= do_read;
    end
  end

endmodule : ram_tile

`default_nettype wire

//--- tb_tiled_ram.sv
// ------------------------------------------------
// Testbench for the tiled RAM, with a reference model and checking assertions
// Run through vlog.f with tb_tiled_ram as the top module
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_tiled_ram;

  import ram_pkg::*;

  // Negedges allowed for the expected responses to drain
  localparam int DRAIN_LIMIT = 32;
  localparam int RAND_REQS   = 300;

  // One expected response slot whose valid bit marks a response that must appear
  typedef struct packed {
    logic     valid;
    ram_rsp_t rsp;
  } exp_t;

  logic     clk;
  logic     rst_n;
  logic     req_valid;
  ram_req_t req;
  logic     rsp_valid;
  ram_rsp_t rsp;

  // Covers the whole address space although only the first DEPTH words are ever written
  logic [DATA_W-1:0] ref_mem [2**ADDR_W];
  // Slot 0 takes the request sampled on the last edge and slot 2 lines up with rsp_valid
  exp_t [2:0]        exp_pipe;
  int                cyc = 0;
  int                errors = 0;
  int                responses = 0;
  logic [31:0]       seed = 32'hb43e_dd6a;

  tiled_ram dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic bit responses_pending();
    bit busy;
    busy = 1'b0;
    for (int i = 0; i < 3; i++) begin
      busy = busy | exp_pipe[i].valid;
    end
    return busy;
  endfunction

  // ------------------------------------------------
  // Reference model
  // ------------------------------------------------

  // Sees the inputs exactly as the DUT samples them on the same edge
  always @(posedge clk) begin : ref_model
    exp_t nxt;
    nxt = '0;
    if (rst_n && req_valid) begin
      if (int'(req.addr) >= DEPTH) begin
        // Out of range, read or write alike, gives an error with zero data
        nxt.valid   = 1'b1;
        nxt.rsp.err = 1'b1;
      end else if (req.op == RAM_OP_WRITE) begin
        ref_mem[req.addr] = req.wdata;
      end else begin
        nxt.valid     = 1'b1;
        nxt.rsp.rdata = ref_mem[req.addr];
      end
    end
    cyc <= cyc + 1;
    if (rst_n && rsp_valid) begin
      responses <= responses + 1;
    end
    if (!rst_n) begin
      exp_pipe <= '0;
    end else begin
      exp_pipe <= {exp_pipe[1:0], nxt};
    end
  end

  // ------------------------------------------------
  // Checks
  // ------------------------------------------------

  // From the second edge on, a response appears exactly when one is expected
  rsp_valid_check: assert property (@(posedge clk)
    (cyc >= 1) |-> (rsp_valid == exp_pipe[2].valid))
    else begin
      errors++;
      $display("MISMATCH rsp_valid expected %h actual %h",
               $sampled(exp_pipe[2].valid), $sampled(rsp_valid));
    end

  rsp_err_check: assert property (@(posedge clk)
    (cyc >= 1 && rsp_valid && exp_pipe[2].valid) |-> (rsp.err == exp_pipe[2].rsp.err))
    else begin
      errors++;
      $display("MISMATCH rsp.err expected %h actual %h",
               $sampled(exp_pipe[2].rsp.err), $sampled(rsp.err));
    end

  rsp_rdata_check: assert property (@(posedge clk)
    (cyc >= 1 && rsp_valid && exp_pipe[2].valid) |-> (rsp.rdata == exp_pipe[2].rsp.rdata))
    else begin
      errors++;
      $display("MISMATCH rsp.rdata expected %h actual %h",
               $sampled(exp_pipe[2].rsp.rdata), $sampled(rsp.rdata));
    end

  // ------------------------------------------------
  // Stimulus tasks
  // ------------------------------------------------

  task automatic send(input ram_op_e op, input logic [ADDR_W-1:0] addr,
                      input logic [DATA_W-1:0] wdata);
    ram_req_t r;
    r.op    = op;
    r.addr  = addr;
    r.wdata = wdata;
    @(posedge clk);
    req_valid <= 1'b1;
    req       <= r;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      req_valid <= 1'b0;
    end
  endtask

  // Stops issuing and waits until every expected response has been checked
  task automatic drain();
    int t;
    t = 0;
    idle(1);
    @(negedge clk);
    while (responses_pending() && t < DRAIN_LIMIT) begin
      @(negedge clk);
      t++;
    end
    if (responses_pending()) begin
      errors++;
      $display("Timeout while waiting for the expected responses to drain");
    end
  endtask

  initial begin : stimulus
    logic [31:0]       r;
    logic [31:0]       g;
    logic [ADDR_W-1:0] a;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    // Quiet bus after reset must stay quiet
    idle(6);

    // Fill every word with a distinct value, then read all of them back
    for (int i = 0; i < DEPTH; i++) begin
      send(RAM_OP_WRITE, ADDR_W'(i), DATA_W'(32'h5a00 + i * 37));
    end
    for (int i = 0; i < DEPTH; i++) begin
      send(RAM_OP_READ, ADDR_W'(i), '0);
    end
    drain();

    // Out-of-range reads and writes, then a readback shows memory untouched
    for (int i = DEPTH; i < 2**ADDR_W; i++) begin
      send(ram_op_e'(i[0]), ADDR_W'(i), DATA_W'(32'hdead ^ i));
    end
    for (int i = 0; i < DEPTH; i++) begin
      send(RAM_OP_READ, ADDR_W'(i), '0);
    end
    drain();

    // Back-to-back reads, a stride of 11 moves to another tile every cycle
    for (int i = 0; i < DEPTH; i++) begin
      send(RAM_OP_READ, ADDR_W'((i * 11) % DEPTH), '0);
    end
    drain();

    // Read right behind a write to the same word
    for (int i = 0; i < 8; i++) begin
      a = ADDR_W'((i * 5 + 2) % DEPTH);
      send(RAM_OP_WRITE, a, DATA_W'(32'hc300 + i));
      send(RAM_OP_READ, a, '0);
    end
    drain();

    // Random mix, mostly in range, with occasional idle gaps
    for (int n = 0; n < RAND_REQS; n++) begin
      seed = lcg_step(seed);
      r    = seed;
      if (r[27:24] == 4'h0) begin
        a = r[21:16];
      end else begin
        a = ADDR_W'(r[23:16] % DEPTH);
      end
      send(ram_op_e'(r[31]), a, r[15:0]);
      seed = lcg_step(seed);
      g    = seed;
      if (g[31:30] == 2'b00) begin
        idle(int'(g[29:28]) + 1);
      end
    end
    drain();

    $display("Responses seen: %0d, errors: %0d", responses, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_tiled_ram

`default_nettype wire

//--- tiled_ram.sv
// ------------------------------------------------
// Top of the tiled scratchpad RAM with one request port and one response port
// Reads and out-of-range requests answer DECODE_STAGES + 2 cycles later
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tiled_ram (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_valid,
  input  ram_pkg::ram_req_t req,
  output logic              rsp_valid,
  output ram_pkg::ram_rsp_t rsp
);

  import ram_pkg::*;

  // ------------------------------------------------
  // Internal wiring
  // ------------------------------------------------

  // Decoder to tiles, at most one valid bit is high at a time
  logic      [TILES-1:0]              tile_valid;
  tile_req_t [TILES-1:0]              tile_req;
  // Decoder to collector, aligned with tile_valid
  logic                               dec_err;
  // Tiles to collector
  logic      [TILES-1:0]              rd_valid;
  logic      [TILES-1:0][DATA_W-1:0]  rdata;

  // ------------------------------------------------
  // Decode
  // ------------------------------------------------

  ram_addr_decoder decoder_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (req_valid),
    .in        (req),
    .out_valid (tile_valid),
    .out       (tile_req),
    .err       (dec_err)
  );

  // ------------------------------------------------
  // Storage tiles
  // ------------------------------------------------

  for (genvar i = 0; i < TILES; i++) begin : gen_tile
    ram_tile tile_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_valid (tile_valid[i]),
      .req       (tile_req[i]),
      .rd_valid  (rd_valid[i]),
      .rdata     (rdata[i])
    );
  end

  // Response merge, also delays dec_err by one cycle internally
  ram_rsp_collect collect_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_valid  (rd_valid),
    .rdata     (rdata),
    .err       (dec_err),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

endmodule : tiled_ram

`default_nettype wire

//--- vlog.f
ram_pkg.sv
ram_delay_valid.sv
ram_addr_decoder.sv
ram_tile.sv
ram_rsp_collect.sv
tiled_ram.sv
tb_tiled_ram.sv
